//--- Bender.yml
package:
  name: addr_remap

sources:
  - include_dirs:
      - include
    files:
      - hdl/addr_remap_pkg.sv
      - hdl/addr_remap_regs.sv
      - hdl/addr_cmd_decode.sv
      - hdl/addr_offset_execute.sv
      - hdl/addr_result_buffer.sv
      - hdl/addr_remap_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/addr_remap_tb.sv

//--- addr_remap_top.f
+incdir+include
hdl/addr_remap_pkg.sv
hdl/addr_remap_regs.sv
hdl/addr_cmd_decode.sv
hdl/addr_offset_execute.sv
hdl/addr_result_buffer.sv
hdl/addr_remap_top.sv
testbench/addr_remap_tb.sv

//--- hdl/addr_cmd_decode.sv
// decode stage of the remap pipeline
// registers incoming commands and scales the word address
// to a byte address, tag passes through

`timescale 1ns/1ps
`default_nettype none

`include "addr_remap_defines.svh"

module addr_cmd_decode (
    input  wire                          aclk,
    input  wire                          arst_n,

    input  wire addr_remap_pkg::cmd_in_t s_cmd,
    input  wire                          s_valid,
    output logic                         s_ready,

    output addr_remap_pkg::cmd_out_t     dec_cmd,
    output logic                         dec_valid,
    input  wire                          dec_ready,

    output logic                         busy
);

    addr_remap_pkg::byte_addr_t scaled_addr;
    logic                       load;

    // --------------------------------------------------
    // handshake
    // --------------------------------------------------

    // free when empty or when the held command leaves this cycle
    assign s_ready = !dec_valid || dec_ready;
    assign load    = s_valid && s_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            dec_valid <= 1'b0;
        else if (s_ready)
            dec_valid <= s_valid;
    end

    // --------------------------------------------------
    // word to byte address
    // --------------------------------------------------

    // zero-extend first so the shift keeps the top bits
    assign scaled_addr = addr_remap_pkg::byte_addr_t'(s_cmd.addr) << `ADDR_REMAP_UNIT_SHIFT;

    always_ff @(posedge aclk) begin
        if (load) begin
            dec_cmd.user <= s_cmd.user;
            dec_cmd.addr <= scaled_addr;
        end
    end

    assign busy = dec_valid;

endmodule

`default_nettype wire

//--- hdl/addr_offset_execute.sv
// execute stage of the remap pipeline
// adds the programmed byte offset when remapping is enabled,
// wrapping modulo 2^32

`timescale 1ns/1ps
`default_nettype none

module addr_offset_execute (
    input  wire                             aclk,
    input  wire                             arst_n,

    input  wire addr_remap_pkg::remap_cfg_t cfg,

    input  wire addr_remap_pkg::cmd_out_t   dec_cmd,
    input  wire                             dec_valid,
    output logic                            dec_ready,

    output addr_remap_pkg::cmd_out_t        exe_cmd,
    output logic                            exe_valid,
    input  wire                             exe_ready,

    output logic                            busy
);

    addr_remap_pkg::byte_addr_t remap_addr;
    logic                       load;

    // --------------------------------------------------
    // handshake
    // --------------------------------------------------

    assign dec_ready = !exe_valid || exe_ready;
    assign load      = dec_valid && dec_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            exe_valid <= 1'b0;
        else if (dec_ready)
            exe_valid <= dec_valid;
    end

    // --------------------------------------------------
    // offset add
    // --------------------------------------------------

    // carry out of bit 31 is dropped
    assign remap_addr = cfg.enable ? dec_cmd.addr + cfg.offset : dec_cmd.addr;

    always_ff @(posedge aclk) begin
        if (load) begin
            exe_cmd.user <= dec_cmd.user;
            exe_cmd.addr <= remap_addr;
        end
    end

    assign busy = exe_valid;

endmodule

`default_nettype wire

//--- hdl/addr_remap_pkg.sv
// address remap types
// field vectors, command structs, remap config
// APB request/response structs and slave FSM states

`default_nettype none

`include "addr_remap_defines.svh"

package addr_remap_pkg;

    typedef logic [`ADDR_REMAP_S_ADDR_W-1:0]   word_addr_t;
    typedef logic [`ADDR_REMAP_M_ADDR_W-1:0]   byte_addr_t;
    typedef logic [`ADDR_REMAP_USER_W-1:0]     user_t;
    typedef logic [31:0]                       apb_data_t;
    typedef logic [`ADDR_REMAP_APB_ADDR_W-1:0] apb_addr_t;

    typedef struct packed {
        user_t      user;
        word_addr_t addr;
    } cmd_in_t;

    typedef struct packed {
        user_t      user;
        byte_addr_t addr;
    } cmd_out_t;

    // offset is only applied while enable is set
    typedef struct packed {
        logic       enable;
        byte_addr_t offset;
    } remap_cfg_t;

    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        apb_idle,
        apb_wait,
        apb_respond
    } apb_state_t;

endpackage

`default_nettype wire

//--- hdl/addr_remap_regs.sv
// APB register block for the remap stage
// CTRL enable, OFFSET, STATUS busy readback, COUNT of delivered commands
// one wait state on every access

`timescale 1ns/1ps
`default_nettype none

`include "addr_remap_defines.svh"

module addr_remap_regs (
    input  wire                         aclk,
    input  wire                         arst_n,
    input  wire addr_remap_pkg::apb_req_t apb_req,
    output addr_remap_pkg::apb_rsp_t    apb_rsp,
    output addr_remap_pkg::remap_cfg_t  cfg,
    input  wire                         dec_busy,
    input  wire                         exe_busy,
    input  wire                         res_busy,
    input  wire                         xfer_done
);

    addr_remap_pkg::apb_state_t state;
    addr_remap_pkg::apb_data_t  rd_mux;
    addr_remap_pkg::apb_data_t  rd_data;
    addr_remap_pkg::apb_data_t  xfer_count;
    addr_remap_pkg::byte_addr_t cfg_offset;
    logic                       cfg_en;
    logic                       addr_hit;
    logic                       rd_err;
    logic                       stat_busy;
    logic                       wr_en;

    assign stat_busy = dec_busy | exe_busy | res_busy;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------

    always_comb begin
        rd_mux   = '0;
        addr_hit = 1'b1;
        case (apb_req.paddr)
            `ADDR_REMAP_REG_CTRL:   rd_mux = addr_remap_pkg::apb_data_t'(cfg_en);
            `ADDR_REMAP_REG_OFFSET: rd_mux = cfg_offset;
            `ADDR_REMAP_REG_STATUS: rd_mux = addr_remap_pkg::apb_data_t'(stat_busy);
            `ADDR_REMAP_REG_COUNT:  rd_mux = xfer_count;
            default:                addr_hit = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // access FSM, setup -> wait -> respond
    // --------------------------------------------------

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= addr_remap_pkg::apb_idle;
        end else begin
            case (state)
                addr_remap_pkg::apb_idle: begin
                    if (apb_req.psel && !apb_req.penable)
                        state <= addr_remap_pkg::apb_wait;
                end
                addr_remap_pkg::apb_wait: begin
                    if (!apb_req.psel)
                        state <= addr_remap_pkg::apb_idle;
                    else if (apb_req.penable)
                        state <= addr_remap_pkg::apb_respond;
                end
                default: state <= addr_remap_pkg::apb_idle;
            endcase
        end
    end

    // sample read data during the wait cycle
    always_ff @(posedge aclk) begin
        if (state == addr_remap_pkg::apb_wait && apb_req.psel && apb_req.penable) begin
            rd_data <= rd_mux;
            rd_err  <= !addr_hit;
        end
    end

    // writes take effect on the completing edge; STATUS writes fall through
    assign wr_en = (state == addr_remap_pkg::apb_respond) && apb_req.psel && apb_req.pwrite;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_en     <= 1'b0;
            cfg_offset <= '0;
        end else if (wr_en) begin
            if (apb_req.paddr == `ADDR_REMAP_REG_CTRL)
                cfg_en <= apb_req.pwdata[0];
            if (apb_req.paddr == `ADDR_REMAP_REG_OFFSET)
                cfg_offset <= apb_req.pwdata;
        end
    end

    // delivered commands, clear wins but still counts a same-cycle delivery
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            xfer_count <= '0;
        else if (wr_en && apb_req.paddr == `ADDR_REMAP_REG_COUNT)
            xfer_count <= addr_remap_pkg::apb_data_t'(xfer_done);
        else if (xfer_done)
            xfer_count <= xfer_count + 1'b1;
    end

    always_comb begin
        apb_rsp.prdata  = rd_data;
        apb_rsp.pready  = (state == addr_remap_pkg::apb_respond);
        apb_rsp.pslverr = (state == addr_remap_pkg::apb_respond) && rd_err;
        cfg.enable      = cfg_en;
        cfg.offset      = cfg_offset;
    end

endmodule

`default_nettype wire

//--- hdl/addr_remap_top.sv
// top level of the address remap stage
// APB register block plus decode, execute and result stages

`timescale 1ns/1ps
`default_nettype none

module addr_remap_top (
    input  wire                           aclk,
    input  wire                           arst_n,

    input  wire addr_remap_pkg::apb_req_t apb_req,
    output addr_remap_pkg::apb_rsp_t      apb_rsp,

    input  wire addr_remap_pkg::cmd_in_t  s_cmd,
    input  wire                           s_valid,
    output logic                          s_ready,

    output addr_remap_pkg::cmd_out_t      m_cmd,
    output logic                          m_valid,
    input  wire                           m_ready
);

    addr_remap_pkg::remap_cfg_t cfg;
    addr_remap_pkg::cmd_out_t   dec_cmd;
    addr_remap_pkg::cmd_out_t   exe_cmd;
    logic                       dec_valid;
    logic                       dec_ready;
    logic                       exe_valid;
    logic                       exe_ready;
    logic                       dec_busy;
    logic                       exe_busy;
    logic                       res_busy;
    logic                       xfer_done;

    // --------------------------------------------------
    // control
    // --------------------------------------------------

    addr_remap_regs u_regs (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cfg       (cfg),
        .dec_busy  (dec_busy),
        .exe_busy  (exe_busy),
        .res_busy  (res_busy),
        .xfer_done (xfer_done)
    );

    // --------------------------------------------------
    // command pipeline
    // --------------------------------------------------

    addr_cmd_decode u_decode (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .s_cmd     (s_cmd),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .dec_cmd   (dec_cmd),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .busy      (dec_busy)
    );

    addr_offset_execute u_execute (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .dec_cmd   (dec_cmd),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .exe_cmd   (exe_cmd),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .busy      (exe_busy)
    );

    addr_result_buffer u_result (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .exe_cmd   (exe_cmd),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .m_cmd     (m_cmd),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .xfer_done (xfer_done),
        .busy      (res_busy)
    );

endmodule

`default_nettype wire

//--- hdl/addr_result_buffer.sv
// result stage of the remap pipeline
// two-entry skid buffer, output and ready both registered
// flags every delivered command

`timescale 1ns/1ps
`default_nettype none

module addr_result_buffer (
    input  wire                           aclk,
    input  wire                           arst_n,

    input  wire addr_remap_pkg::cmd_out_t exe_cmd,
    input  wire                           exe_valid,
    output logic                          exe_ready,

    output addr_remap_pkg::cmd_out_t      m_cmd,
    output logic                          m_valid,
    input  wire                           m_ready,

    output logic                          xfer_done,
    output logic                          busy
);

    addr_remap_pkg::cmd_out_t skid_cmd;
    logic                     skid_valid;
    logic                     out_free;
    logic                     take;

    // ready comes straight from a flop, so no path from m_ready
    assign exe_ready = !skid_valid;
    assign take      = exe_valid && exe_ready;
    assign out_free  = !m_valid || m_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // skid entry drains first
            m_valid    <= skid_valid || take;
            skid_valid <= 1'b0;
        end else if (take) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_free)
            m_cmd <= skid_valid ? skid_cmd : exe_cmd;
        else if (take)
            skid_cmd <= exe_cmd;
    end

    assign xfer_done = m_valid && m_ready;
    assign busy      = m_valid || skid_valid;

endmodule

`default_nettype wire

//--- include/addr_remap_defines.svh
// address remap stage, project-wide widths
// command field widths and unit scaling
// APB address width and register byte offsets

`ifndef ADDR_REMAP_DEFINES_SVH
`define ADDR_REMAP_DEFINES_SVH

// --------------------------------------------------
// command path widths
// --------------------------------------------------

// incoming word address, 64-bit units
`define ADDR_REMAP_S_ADDR_W     29
// log2 of bytes per incoming word
`define ADDR_REMAP_UNIT_SHIFT   3
// outgoing byte address
`define ADDR_REMAP_M_ADDR_W     32
`define ADDR_REMAP_USER_W       8

// --------------------------------------------------
// register map
// --------------------------------------------------

`define ADDR_REMAP_APB_ADDR_W   12

`define ADDR_REMAP_REG_CTRL     12'h000
`define ADDR_REMAP_REG_OFFSET   12'h004
`define ADDR_REMAP_REG_STATUS   12'h008
`define ADDR_REMAP_REG_COUNT    12'h00C

`endif

//--- testbench/addr_remap_tb.sv
// testbench for the address remap stage
// stimulus table of remap settings and command sequences
// APB read/write tasks, command driver, output checker on a queue
// random output back-pressure on selected rows

`timescale 1ns/1ps
`default_nettype none

`include "addr_remap_defines.svh"

module addr_remap_tb;

    localparam int NUM_ROWS      = 6;
    localparam int APB_TIMEOUT   = 20;
    localparam int CMD_TIMEOUT   = 50;
    localparam int DRAIN_TIMEOUT = 400;
    // accepting edge counts as the first of three register stages
    localparam int PIPE_EDGES    = 3;

    // one row of the stimulus table
    typedef struct packed {
        logic        enable;
        logic [31:0] offset;
        logic [15:0] num_cmds;
        logic [28:0] start;
        logic [28:0] step;
        logic        backpressure;
    } row_t;

    logic                       aclk;
    logic                       arst_n;
    addr_remap_pkg::apb_req_t   apb_req;
    addr_remap_pkg::apb_rsp_t   apb_rsp;
    addr_remap_pkg::cmd_in_t    s_cmd;
    logic                       s_valid;
    logic                       s_ready;
    addr_remap_pkg::cmd_out_t   m_cmd;
    logic                       m_valid;
    logic                       m_ready;

    row_t                       rows [0:NUM_ROWS-1];
    addr_remap_pkg::cmd_out_t   exp_q [$];
    addr_remap_pkg::cmd_out_t   exp_head;
    logic                       bp_on;
    logic                       hold_out;
    logic                       cur_en;
    logic [31:0]                cur_offset;
    logic [7:0]                 next_tag;
    int                         errors;
    int                         tests_run;
    int                         tests_ok;
    int                         seed_value;

    addr_remap_top dut (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .s_cmd   (s_cmd),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_cmd   (m_cmd),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    always #4 aclk = ~aclk;

    // random output back-pressure on rows that ask for it
    always @(posedge aclk) begin
        #1;
        if (hold_out)
            m_ready = 1'b0;
        else if (bp_on)
            m_ready = ($urandom % 3) != 0;
        else
            m_ready = 1'b1;
    end

    // --------------------------------------------------
    // checks and expected values
    // --------------------------------------------------

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // 64-bit words, so eight bytes per word; offset sum wraps at 32 bits
    function automatic addr_remap_pkg::cmd_out_t expected_cmd(
        input addr_remap_pkg::word_addr_t word, input addr_remap_pkg::user_t tag);
        addr_remap_pkg::cmd_out_t cmd;
        logic [31:0]              byte_addr;
        byte_addr = {3'b000, word} * 32'd8;
        if (cur_en)
            byte_addr = byte_addr + cur_offset;
        cmd.user = tag;
        cmd.addr = byte_addr;
        return cmd;
    endfunction

    // commands leave m in the order they were sent
    always @(negedge aclk) begin
        if (arst_n && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                $display("output delivered a command that was never sent, tag %h", m_cmd.user);
                errors++;
            end else begin
                exp_head = exp_q.pop_front();
                check_value(m_cmd, exp_head, "output command {tag, byte address}");
            end
        end
    end

    // --------------------------------------------------
    // APB access
    // --------------------------------------------------

    task automatic apb_transfer(input addr_remap_pkg::apb_addr_t addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge aclk);
        #1;
        apb_req.penable = 1'b1;
        waited = 0;
        do begin
            @(posedge aclk);
            #1;
            waited++;
        end while (!apb_rsp.pready && waited < APB_TIMEOUT);
        if (!apb_rsp.pready) begin
            $display("APB access to %h timed out, pready never came", addr);
            errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // transfer completes on this edge
        @(posedge aclk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input addr_remap_pkg::apb_addr_t addr, input logic [31:0] data);
        logic [31:0] unused_data;
        logic        unused_err;
        apb_transfer(addr, 1'b1, data, unused_data, unused_err);
    endtask

    task automatic apb_read(input addr_remap_pkg::apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(addr, 1'b0, 32'd0, data, err);
    endtask

    task automatic read_expect(input addr_remap_pkg::apb_addr_t addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value(data, expected, what);
        check_value(err, 1'b0, {what, " pslverr"});
    endtask

    // --------------------------------------------------
    // command side
    // --------------------------------------------------

    task automatic send_cmd(input addr_remap_pkg::word_addr_t word);
        int waited;
        exp_q.push_back(expected_cmd(word, next_tag));
        s_cmd.user = next_tag;
        s_cmd.addr = word;
        s_valid    = 1'b1;
        next_tag   = next_tag + 8'd1;
        waited     = 0;
        while (!s_ready && waited < CMD_TIMEOUT) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        if (!s_ready) begin
            $display("command input stalled, s_ready stayed low for %0d cycles", CMD_TIMEOUT);
            errors++;
        end
        // accepted on this edge
        @(posedge aclk);
        #1;
        s_valid = 1'b0;
    endtask

    task automatic measure_latency(input addr_remap_pkg::word_addr_t word, output int edges);
        send_cmd(word);
        edges = 1;
        while (!m_valid && edges < CMD_TIMEOUT) begin
            @(posedge aclk);
            #1;
            edges++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || m_valid) && waited < DRAIN_TIMEOUT) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 || m_valid) begin
            $display("pipeline did not drain, %0d commands still missing", exp_q.size());
            errors++;
        end
    endtask

    task automatic finish_test(input int id, input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %0d %s: ok", id, name);
        end else begin
            $display("test %0d %s: %0d errors", id, name, errors - errs_before);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial begin : main
        row_t                       row;
        addr_remap_pkg::word_addr_t word;
        logic [31:0]                rdata;
        logic                       rerr;
        int                         errs_before;
        int                         edges;

        aclk       = 1'b0;
        arst_n     = 1'b0;
        apb_req    = '0;
        s_cmd      = '0;
        s_valid    = 1'b0;
        m_ready    = 1'b1;
        bp_on      = 1'b0;
        hold_out   = 1'b0;
        cur_en     = 1'b0;
        cur_offset = 32'd0;
        next_tag   = 8'd0;
        errors     = 0;
        tests_run  = 0;
        tests_ok   = 0;
        seed_value = $urandom(85443);

        // enable, offset, commands, start word, step, back-pressure
        rows[0] = {1'b0, 32'h0000_0000, 16'd8,  29'h000_0000, 29'd1,  1'b0};
        rows[1] = {1'b0, 32'hdead_beef, 16'd6,  29'h1fff_fff0, 29'd3, 1'b0};
        rows[2] = {1'b1, 32'h0000_1000, 16'd8,  29'h000_0100, 29'd2,  1'b0};
        rows[3] = {1'b1, 32'hffff_ff00, 16'd6,  29'h000_001c, 29'd8,  1'b0};
        rows[4] = {1'b1, 32'h8000_0000, 16'd40, 29'h1fff_ff00, 29'd5, 1'b1};
        rows[5] = {1'b0, 32'h0000_0000, 16'd30, 29'h000_0007, 29'd11, 1'b1};

        repeat (4) @(posedge aclk);
        #1;
        arst_n = 1'b1;

        // reset values and an unmapped address
        errs_before = errors;
        check_value(s_ready, 1'b1, "s_ready after reset");
        check_value(m_valid, 1'b0, "m_valid after reset");
        check_value(apb_rsp.pready, 1'b0, "pready after reset");
        read_expect(`ADDR_REMAP_REG_CTRL, 32'd0, "CTRL after reset");
        read_expect(`ADDR_REMAP_REG_OFFSET, 32'd0, "OFFSET after reset");
        read_expect(`ADDR_REMAP_REG_STATUS, 32'd0, "STATUS after reset");
        read_expect(`ADDR_REMAP_REG_COUNT, 32'd0, "COUNT after reset");
        apb_read(12'h010, rdata, rerr);
        check_value(rerr, 1'b1, "pslverr for address 0x10");
        finish_test(1, "reset values", errs_before);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row         = rows[r];
            errs_before = errors;
            apb_write(`ADDR_REMAP_REG_CTRL, {31'd0, row.enable});
            apb_write(`ADDR_REMAP_REG_OFFSET, row.offset);
            apb_write(`ADDR_REMAP_REG_COUNT, 32'd0);
            read_expect(`ADDR_REMAP_REG_CTRL, {31'd0, row.enable}, "CTRL readback");
            read_expect(`ADDR_REMAP_REG_OFFSET, row.offset, "OFFSET readback");
            cur_en     = row.enable;
            cur_offset = row.offset;
            bp_on      = row.backpressure;
            word       = row.start;
            for (int i = 0; i < row.num_cmds; i++) begin
                send_cmd(word);
                word = word + row.step;
            end
            wait_drain();
            bp_on = 1'b0;
            read_expect(`ADDR_REMAP_REG_STATUS, 32'd0, "STATUS after drain");
            read_expect(`ADDR_REMAP_REG_COUNT, {16'd0, row.num_cmds}, "COUNT after drain");
            finish_test(r + 2, "stimulus row", errs_before);
        end

        // single command latency, then counter clear
        errs_before = errors;
        apb_write(`ADDR_REMAP_REG_CTRL, 32'd1);
        apb_write(`ADDR_REMAP_REG_OFFSET, 32'h0000_0040);
        apb_write(`ADDR_REMAP_REG_COUNT, 32'd0);
        cur_en     = 1'b1;
        cur_offset = 32'h0000_0040;
        measure_latency(29'h000_0abc, edges);
        check_value(edges, PIPE_EDGES, "edges from acceptance to m_valid");
        wait_drain();
        read_expect(`ADDR_REMAP_REG_COUNT, 32'd1, "COUNT after one command");
        apb_write(`ADDR_REMAP_REG_COUNT, 32'd0);
        read_expect(`ADDR_REMAP_REG_COUNT, 32'd0, "COUNT after clear");

        // a command parked at the output keeps STATUS busy
        hold_out = 1'b1;
        send_cmd(29'h000_0123);
        read_expect(`ADDR_REMAP_REG_STATUS, 32'd1, "STATUS while a command is held");
        hold_out = 1'b0;
        wait_drain();
        read_expect(`ADDR_REMAP_REG_STATUS, 32'd0, "STATUS after final drain");
        finish_test(NUM_ROWS + 2, "latency, count clear and busy", errs_before);

        $display("summary: %0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
